// File: exu.f
hw/exu_pkg.sv
hw/exu_alu.sv
hw/exu_branch.sv
hw/exu_core.sv
hw/exu_lsu.sv
hw/exu_top.sv
tb/tb_clk_gen.sv
tb/tb_exu_checker.sv
tb/tb_exu_top.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert
TOP      := tb_exu_top
FILELIST := exu.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tb/tb_exu_top.sv
module tb_exu_top;

  import exu_pkg::*;

  typedef struct packed {
    logic [31:0] npc;
    gpr_wr_t     gpr;
    csr_wr_t     csr1;
    csr_wr_t     csr2;
    logic        mem_we;
    logic [7:0]  mem_idx;
    logic [31:0] mem_word;
  } exp_t;

  localparam int READY_TIMEOUT = 50;

  logic        clk, rstn;
  logic        id_valid, id_ready;
  id_pkt_t     id_pkt;
  logic [31:0] npc;
  gpr_wr_t     gpr_wr;
  csr_wr_t     csr_wr1, csr_wr2;
  logic        hung; // some wait ran out
  logic [31:0] ref_mem [DMEM_WORDS];
  logic [2:0]  br_list [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  logic [2:0]  ld_list [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

  tb_clk_gen u_clk (
    .clk  (clk),
    .rstn (rstn)
  );

  exu_top DUT (
    .clk      (clk),
    .rstn     (rstn),
    .id_valid (id_valid),
    .id_ready (id_ready),
    .id_pkt   (id_pkt),
    .npc      (npc),
    .gpr_wr   (gpr_wr),
    .csr_wr1  (csr_wr1),
    .csr_wr2  (csr_wr2)
  );

  tb_exu_checker u_chk (
    .clk     (clk),
    .rstn    (rstn),
    .gpr_wr  (gpr_wr),
    .csr_wr1 (csr_wr1),
    .csr_wr2 (csr_wr2)
  );

  function automatic logic [31:0] alu_ref(logic [31:0] a, logic [31:0] b, alu_funct_e f,
                                          logic s);
    logic signed [31:0] sa;
    sa = a;
    case (f)
      ALU_ADD:  return s ? a - b : a + b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'b0, a < b};
      ALU_XOR:  return a ^ b;
      ALU_SR: begin
        if (s) begin
          return sa >>> b[4:0];
        end
        return a >> b[4:0];
      end
      ALU_OR:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  function automatic exp_t exec_ref(id_pkt_t p, logic [31:0] m [DMEM_WORDS]);
    exp_t        e;
    logic [31:0] alu, base, inc, addr, w, sh;
    logic        taken, sysj;
    int          off;
    e     = '0;
    alu   = alu_ref(p.alu_a, p.alu_b, p.alu_funct, p.alu_funcs);
    sysj  = (p.opcode == OP_SYS) && (p.funct == 3'b000);
    case (p.funct)
      3'd0:    taken = p.src1 == p.src2;
      3'd1:    taken = p.src1 != p.src2;
      3'd4:    taken = $signed(p.src1) < $signed(p.src2);
      3'd5:    taken = $signed(p.src1) >= $signed(p.src2);
      3'd6:    taken = p.src1 < p.src2;
      3'd7:    taken = p.src1 >= p.src2;
      default: taken = 1'b0;
    endcase
    base = (p.opcode == OP_JALR) ? p.src1 : (sysj ? p.csr : p.pc);
    if (p.opcode inside {OP_JAL, OP_JALR} || (p.opcode == OP_BRANCH && taken)) begin
      inc = p.imm;
    end else begin
      inc = sysj ? 32'd0 : 32'd4;
    end
    e.npc       = (base + inc) & ~32'd1;
    e.gpr.waddr = p.rd;
    addr        = p.src1 + p.imm;
    w           = m[addr[9:2]];
    off         = int'(addr[1:0]);
    sh          = w >> (8 * off);
    case (p.opcode)
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_CALRI, OP_CALRR: begin
        e.gpr.wen   = 1'b1;
        e.gpr.wdata = alu;
      end
      OP_SYS: begin
        e.gpr.wen    = p.funct != 3'b000;
        e.gpr.wdata  = p.csr;
        e.csr1.wen   = (p.funct != 3'b000) || (p.imm[11:0] == 12'h000);
        e.csr1.waddr = (p.funct != 3'b000) ? p.imm[11:0] : CSR_MEPC;
        e.csr1.wdata = alu;
        e.csr2.wen   = sysj && (p.imm[11:0] == 12'h000);
        e.csr2.waddr = CSR_MCAUSE;
        e.csr2.wdata = CAUSE_ECALL;
      end
      OP_LOAD: begin
        e.gpr.wen = 1'b1;
        case (p.funct)
          3'd0:    e.gpr.wdata = {{24{sh[7]}}, sh[7:0]};
          3'd1:    e.gpr.wdata = {{16{sh[15]}}, sh[15:0]};
          3'd4:    e.gpr.wdata = {24'b0, sh[7:0]};
          3'd5:    e.gpr.wdata = {16'b0, sh[15:0]};
          default: e.gpr.wdata = w;
        endcase
      end
      OP_STORE: begin
        case (p.funct)
          3'd0:    w[off*8 +: 8] = p.src2[7:0];
          3'd1:    w[off*8 +: 16] = p.src2[15:0];
          default: w = p.src2;
        endcase
        e.mem_we   = 1'b1;
        e.mem_idx  = addr[9:2];
        e.mem_word = w;
      end
      default: ;
    endcase
    return e;
  endfunction

  function automatic id_pkt_t at_addr(id_pkt_t p, logic [31:0] addr);
    p.src1  = addr - p.imm;
    p.alu_a = p.src1;
    return p;
  endfunction

  // fills a packet as the decoder would
  function automatic id_pkt_t build(opcode_e op, logic [2:0] f, logic s);
    id_pkt_t     p;
    logic [31:0] r;
    logic [1:0]  off;
    r           = $urandom();
    p.pc        = $urandom() & ~32'h3;
    p.src1      = $urandom();
    p.src2      = $urandom();
    p.imm       = {{20{r[11]}}, r[11:0]};
    p.csr       = $urandom();
    p.opcode    = op;
    p.funct     = f;
    p.rd        = 5'($urandom());
    p.alu_a     = p.src1;
    p.alu_b     = p.imm;
    p.alu_funct = ALU_ADD;
    p.alu_funcs = 1'b0;
    case (op)
      OP_CALRR, OP_CALRI: begin
        if (op == OP_CALRR) p.alu_b = p.src2;
        p.alu_funct = alu_funct_e'(f);
        p.alu_funcs = s;
      end
      OP_LUI, OP_AUIPC: begin
        p.imm   = r & 32'hffff_f000;
        p.alu_a = (op == OP_LUI) ? 32'd0 : p.pc;
        p.alu_b = p.imm;
      end
      OP_JAL, OP_JALR: begin
        if (op == OP_JAL) begin
          p.imm = {{11{r[20]}}, r[20:1], 1'b0};
        end else begin
          p.src1   = p.src1 | 32'd1; // odd target
          p.imm[0] = 1'b0;
        end
        p.alu_a = p.pc; // link value
        p.alu_b = 32'd4;
      end
      OP_BRANCH: begin
        p.imm   = {{19{r[12]}}, r[12:1], 1'b0};
        p.alu_b = p.src2;
        if (f[2:1] == 2'b00) p.alu_funcs = 1'b1;
        else p.alu_funct = f[1] ? ALU_SLTU : ALU_SLT;
      end
      OP_LOAD, OP_STORE: begin
        off = 2'($urandom());
        if (f[1:0] == 2'd2) off = 2'd0;
        else if (f[0]) off[0] = 1'b0;
        p = at_addr(p, {22'b0, 8'($urandom()), off});
      end
      OP_SYS: begin
        p.alu_b = 32'd0;
        p.alu_a = (f != 3'b000) ? p.src1 : p.pc;
        if (f != 3'b000) p.imm = {20'b0, 12'h300 | {4'b0, r[7:0]}};
        else p.imm = s ? 32'h302 : 32'h0; // mret or ecall
      end
      default: ;
    endcase
    return p;
  endfunction

  task automatic abort(string why);
    $display("timeout: %s", why);
    hung = 1'b1;
  endtask

  // a stuck handshake ends the run here
  initial begin
    wait (hung);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // drive one packet and predict its result at acceptance
  task automatic issue(id_pkt_t p);
    exp_t e;
    int   waited;
    @(posedge clk);
    id_valid <= 1'b1;
    id_pkt   <= p;
    waited = 0;
    @(negedge clk);
    while (!id_ready) begin
      waited++;
      if (waited > READY_TIMEOUT) abort("id_ready stayed low");
      @(negedge clk);
    end
    e = exec_ref(p, ref_mem);
    u_chk.compare("npc", e.npc, npc);
    if (e.gpr.wen) u_chk.expect_gpr(e.gpr);
    if (e.csr1.wen) u_chk.expect_csr1(e.csr1);
    if (e.csr2.wen) u_chk.expect_csr2(e.csr2);
    if (e.mem_we) ref_mem[e.mem_idx] = e.mem_word;
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      id_valid <= 1'b0;
    end
  endtask

  task automatic finish_test(string name);
    int waited;
    idle(1);
    waited = 0;
    @(negedge clk);
    while (u_chk.pending() != 0 || !id_ready) begin
      waited++;
      if (waited > 100) abort("writes still outstanding at end of test");
      @(negedge clk);
    end
    u_chk.report_test(name);
  endtask

  initial begin
    int          waited;
    id_pkt_t     p;
    logic [31:0] base;
    int          k;
    void'($urandom(16));
    id_valid = 1'b0;
    id_pkt   = '0;
    hung     = 1'b0;
    waited   = 0;
    @(posedge clk);
    while (rstn) begin
      waited++;
      if (waited > 20) abort("reset never released");
      @(posedge clk);
    end

    for (int f = 0; f < 8; f++) begin
      for (int s = 0; s < 2; s++) begin
        issue(build(OP_CALRR, 3'(f), s[0]));
        issue(build(OP_CALRI, 3'(f), s[0]));
      end
    end
    issue(build(OP_LUI, 3'd0, 1'b0));
    issue(build(OP_AUIPC, 3'd0, 1'b0));
    p    = build(OP_CALRR, 3'd0, 1'b0);
    p.rd = 5'd0; // x0 still gets its pulse
    issue(p);
    finish_test("alu writeback");

    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 3; j++) begin
        p = build(OP_BRANCH, br_list[i], 1'b0);
        if (j == 0) p.src2 = p.src1; // equal operands
        if (j == 2) {p.src1, p.src2} = {p.src2, p.src1};
        p.alu_a = p.src1;
        p.alu_b = p.src2;
        issue(p);
      end
    end
    issue(build(OP_JAL, 3'd0, 1'b0));
    issue(build(OP_JALR, 3'd0, 1'b0));
    finish_test("branches and jumps");

    // whole memory first, pattern from the word index
    for (int i = 0; i < DMEM_WORDS; i++) begin
      p      = build(OP_STORE, 3'd2, 1'b0);
      p.src2 = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] ^ 8'hc3};
      issue(at_addr(p, 32'(i * 4)));
    end
    base = {22'b0, 8'($urandom()), 2'b00};
    for (int o = 0; o < 4; o++) begin
      issue(at_addr(build(OP_STORE, 3'd0, 1'b0), base + 32'(o)));
      issue(at_addr(build(OP_LOAD, 3'd0, 1'b0), base + 32'(o)));
      issue(at_addr(build(OP_LOAD, 3'd4, 1'b0), base + 32'(o)));
    end
    for (int o = 0; o < 4; o += 2) begin
      issue(at_addr(build(OP_STORE, 3'd1, 1'b0), base + 32'(o)));
      issue(at_addr(build(OP_LOAD, 3'd1, 1'b0), base + 32'(o)));
      issue(at_addr(build(OP_LOAD, 3'd5, 1'b0), base + 32'(o)));
    end
    issue(at_addr(build(OP_STORE, 3'd2, 1'b0), base));
    issue(at_addr(build(OP_LOAD, 3'd2, 1'b0), base));
    finish_test("stores then loads");

    issue(build(OP_SYS, 3'd1, 1'b0));
    issue(build(OP_SYS, 3'd0, 1'b0)); // ecall
    issue(build(OP_SYS, 3'd0, 1'b1)); // mret
    finish_test("system instructions");

    for (int n = 0; n < 300; n++) begin
      k = int'($urandom() % 12);
      case (k)
        0, 1:    p = build(OP_CALRR, 3'($urandom()), 1'($urandom()));
        2, 3:    p = build(OP_CALRI, 3'($urandom()), 1'($urandom()));
        4:       p = build($urandom() % 2 == 0 ? OP_LUI : OP_AUIPC, 3'd0, 1'b0);
        5:       p = build(OP_BRANCH, br_list[$urandom() % 6], 1'b0);
        6:       p = build($urandom() % 2 == 0 ? OP_JAL : OP_JALR, 3'd0, 1'b0);
        7, 8:    p = build(OP_LOAD, ld_list[$urandom() % 5], 1'b0);
        9, 10:   p = build(OP_STORE, 3'($urandom() % 3), 1'b0);
        default: p = build(OP_SYS, 3'($urandom() % 4), 1'($urandom()));
      endcase
      issue(p);
      if ($urandom() % 4 == 0) idle(int'($urandom() % 3) + 1);
    end
    finish_test("random mix");

    u_chk.final_report();
    if (u_chk.failures() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: tb/tb_exu_checker.sv
module tb_exu_checker (
  input  logic              clk,
  input  logic              rstn,
  input  exu_pkg::gpr_wr_t  gpr_wr,
  input  exu_pkg::csr_wr_t  csr_wr1,
  input  exu_pkg::csr_wr_t  csr_wr2
);

  import exu_pkg::*;

  localparam int PULSE_TIMEOUT = 20;

  gpr_wr_t gpr_q [$];
  csr_wr_t csr1_q [$];
  csr_wr_t csr2_q [$];
  int      gpr_age, csr1_age, csr2_age; // cycles the oldest entry has waited
  int      test_errors, total_errors;
  int      tests_passed, tests_failed;
  int      test_no;
  gpr_wr_t exp_g;
  csr_wr_t exp_c1, exp_c2;

  initial begin
    gpr_age      = 0;
    csr1_age     = 0;
    csr2_age     = 0;
    test_errors  = 0;
    total_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_no      = 0;
  end

  task automatic compare(string sig, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("FAILED %s expected %h actual %h", sig, exp, act);
      test_errors++;
    end
  endtask

  task automatic complain(string what);
    $display("ERROR %s", what);
    test_errors++;
  endtask

  task automatic expect_gpr(gpr_wr_t e);
    gpr_q.push_back(e);
  endtask

  task automatic expect_csr1(csr_wr_t e);
    csr1_q.push_back(e);
  endtask

  task automatic expect_csr2(csr_wr_t e);
    csr2_q.push_back(e);
  endtask

  function automatic int pending();
    return gpr_q.size() + csr1_q.size() + csr2_q.size();
  endfunction

  function automatic int failures();
    return tests_failed + test_errors;
  endfunction

  task automatic report_test(string name);
    test_no++;
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0d %s: ok", test_no, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", test_no, name, test_errors);
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  task automatic final_report();
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             total_errors);
  endtask

  // outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (!rstn) begin
      if (gpr_wr.wen) begin
        if (gpr_q.size() == 0) begin
          complain("gpr_wr pulse arrived with nothing expected");
        end else begin
          exp_g = gpr_q.pop_front();
          compare("gpr_wr.waddr", 32'(exp_g.waddr), 32'(gpr_wr.waddr));
          compare("gpr_wr.wdata", exp_g.wdata, gpr_wr.wdata);
        end
        gpr_age = 0;
      end else if (gpr_q.size() > 0) begin
        gpr_age++;
        if (gpr_age > PULSE_TIMEOUT) begin
          complain("expected gpr_wr pulse never came");
          gpr_q.delete(0);
          gpr_age = 0;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (!rstn) begin
      if (csr_wr1.wen) begin
        if (csr1_q.size() == 0) begin
          complain("csr_wr1 pulse arrived with nothing expected");
        end else begin
          exp_c1 = csr1_q.pop_front();
          compare("csr_wr1.waddr", 32'(exp_c1.waddr), 32'(csr_wr1.waddr));
          compare("csr_wr1.wdata", exp_c1.wdata, csr_wr1.wdata);
        end
        csr1_age = 0;
      end else if (csr1_q.size() > 0) begin
        csr1_age++;
        if (csr1_age > PULSE_TIMEOUT) begin
          complain("expected csr_wr1 pulse never came");
          csr1_q.delete(0);
          csr1_age = 0;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (!rstn) begin
      if (csr_wr2.wen) begin
        if (csr2_q.size() == 0) begin
          complain("csr_wr2 pulse arrived with nothing expected");
        end else begin
          exp_c2 = csr2_q.pop_front();
          compare("csr_wr2.waddr", 32'(exp_c2.waddr), 32'(csr_wr2.waddr));
          compare("csr_wr2.wdata", exp_c2.wdata, csr_wr2.wdata);
        end
        csr2_age = 0;
      end else if (csr2_q.size() > 0) begin
        csr2_age++;
        if (csr2_age > PULSE_TIMEOUT) begin
          complain("expected csr_wr2 pulse never came");
          csr2_q.delete(0);
          csr2_age = 0;
        end
      end
    end
  end

endmodule

// File: tb/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // period 10
  end

  // rstn high means reset
  initial begin
    rstn = 1'b1;
    repeat (3) @(posedge clk);
    rstn <= 1'b0;
  end

endmodule

// File: hw/exu_top.sv
module exu_top (
  input  logic              clk,
  input  logic              rstn,
  input  logic              id_valid,
  output logic              id_ready,
  input  exu_pkg::id_pkt_t  id_pkt,
  output logic [31:0]       npc,
  output exu_pkg::gpr_wr_t  gpr_wr,
  output exu_pkg::csr_wr_t  csr_wr1,
  output exu_pkg::csr_wr_t  csr_wr2
);

  import exu_pkg::*;

  // read channels
  logic        mem_rreq_valid, mem_rreq_ready;
  mem_rreq_t   mem_rreq;
  logic        mem_rres_valid, mem_rres_ready;
  logic [31:0] mem_rdata;
  // write channels
  logic        mem_wreq_valid, mem_wreq_ready;
  mem_wreq_t   mem_wreq;
  logic        mem_wres_valid, mem_wres_ready;

  exu_core u_core (
    .clk            (clk),
    .rstn           (rstn),
    .id_valid       (id_valid),
    .id_pkt         (id_pkt),
    .id_ready       (id_ready),
    .npc            (npc),
    .gpr_wr         (gpr_wr),
    .csr_wr1        (csr_wr1),
    .csr_wr2        (csr_wr2),
    .mem_rreq_valid (mem_rreq_valid),
    .mem_rreq_ready (mem_rreq_ready),
    .mem_rreq       (mem_rreq),
    .mem_rres_valid (mem_rres_valid),
    .mem_rres_ready (mem_rres_ready),
    .mem_rdata      (mem_rdata),
    .mem_wreq_valid (mem_wreq_valid),
    .mem_wreq_ready (mem_wreq_ready),
    .mem_wreq       (mem_wreq),
    .mem_wres_valid (mem_wres_valid),
    .mem_wres_ready (mem_wres_ready)
  );

  exu_lsu u_lsu (
    .clk        (clk),
    .rstn       (rstn),
    .rreq_valid (mem_rreq_valid),
    .rreq_ready (mem_rreq_ready),
    .rreq       (mem_rreq),
    .rres_valid (mem_rres_valid),
    .rres_ready (mem_rres_ready),
    .rdata      (mem_rdata),
    .wreq_valid (mem_wreq_valid),
    .wreq_ready (mem_wreq_ready),
    .wreq       (mem_wreq),
    .wres_valid (mem_wres_valid),
    .wres_ready (mem_wres_ready)
  );

endmodule

// File: hw/exu_lsu.sv
module exu_lsu (
  input  logic                clk,
  input  logic                rstn,
  input  logic                rreq_valid,
  output logic                rreq_ready,
  input  exu_pkg::mem_rreq_t  rreq,
  output logic                rres_valid,
  input  logic                rres_ready,
  output logic [31:0]         rdata,
  input  logic                wreq_valid,
  output logic                wreq_ready,
  input  exu_pkg::mem_wreq_t  wreq,
  output logic                wres_valid,
  input  logic                wres_ready
);

  import exu_pkg::*;

  logic [31:0]        mem [DMEM_WORDS];
  logic               pend;    // response waiting
  logic               pend_rd; // kind of the waiting response
  logic               rfire, wfire;
  logic [1:0]         woff;
  logic [3:0]         wstrb;
  logic [31:0]        wlanes;
  logic [31:0]        rword;
  logic [31:0]        rsh;
  logic [31:0]        rval;

  assign rreq_ready = ~pend;
  assign wreq_ready = ~pend & ~rreq_valid; // read wins a tie
  assign rfire      = rreq_valid & rreq_ready;
  assign wfire      = wreq_valid & wreq_ready;
  assign rres_valid = pend & pend_rd;
  assign wres_valid = pend & ~pend_rd;

  assign woff = wreq.waddr[1:0];
  always_comb begin
    case (wreq.wfunc)
      MEM_B, MEM_BU: begin
        wstrb  = 4'b0001 << woff;
        wlanes = {4{wreq.wdata[7:0]}};
      end
      MEM_H, MEM_HU: begin
        wstrb  = 4'b0011 << {woff[1], 1'b0};
        wlanes = {2{wreq.wdata[15:0]}};
      end
      default: begin
        wstrb  = 4'b1111;
        wlanes = wreq.wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (wfire && wstrb[i]) begin
        mem[wreq.waddr[DMEM_AW+1:2]][i*8 +: 8] <= wlanes[i*8 +: 8];
      end
    end
  end

  assign rword = mem[rreq.raddr[DMEM_AW+1:2]];
  assign rsh   = rword >> {rreq.raddr[1:0], 3'b000}; // addressed byte to lane 0
  always_comb begin
    case (rreq.rfunc)
      MEM_B:   rval = {{24{rsh[7]}}, rsh[7:0]};
      MEM_BU:  rval = {24'b0, rsh[7:0]};
      MEM_H:   rval = {{16{rsh[15]}}, rsh[15:0]};
      MEM_HU:  rval = {16'b0, rsh[15:0]};
      default: rval = rword;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rfire) begin
      rdata <= rval;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      pend    <= 1'b0;
      pend_rd <= 1'b0;
    end else if (rfire || wfire) begin
      pend    <= 1'b1;
      pend_rd <= rfire;
    end else if ((rres_valid && rres_ready) || (wres_valid && wres_ready)) begin
      pend <= 1'b0;
    end
  end

  // every response answers a request taken the cycle before
  assert property (@(posedge clk) disable iff (rstn) $rose(rres_valid) |-> $past(rfire));
  assert property (@(posedge clk) disable iff (rstn) $rose(wres_valid) |-> $past(wfire));

endmodule

// File: hw/exu_core.sv
module exu_core (
  input  logic                clk,
  input  logic                rstn,
  input  logic                id_valid,
  input  exu_pkg::id_pkt_t    id_pkt,
  output logic                id_ready,
  output logic [31:0]         npc,
  output exu_pkg::gpr_wr_t    gpr_wr,
  output exu_pkg::csr_wr_t    csr_wr1,
  output exu_pkg::csr_wr_t    csr_wr2,
  output logic                mem_rreq_valid,
  input  logic                mem_rreq_ready,
  output exu_pkg::mem_rreq_t  mem_rreq,
  input  logic                mem_rres_valid,
  output logic                mem_rres_ready,
  input  logic [31:0]         mem_rdata,
  output logic                mem_wreq_valid,
  input  logic                mem_wreq_ready,
  output exu_pkg::mem_wreq_t  mem_wreq,
  input  logic                mem_wres_valid,
  output logic                mem_wres_ready
);

  import exu_pkg::*;

  typedef enum logic [2:0] {IDLE, LD_REQ, LD_WAIT, ST_REQ, ST_WAIT} state_e;

  state_e      state;
  logic [31:0] alu_val;
  logic        id_fire, rres_fire, wres_fire;
  logic        is_sys, is_load, is_store, ecall;
  logic        gpr_wen_d, csr_wen1_d;
  logic [31:0] gpr_wdata_d;
  logic [11:0] csr_addr;
  logic [4:0]  rd_q;
  logic [31:0] alu_q;
  logic [31:0] src2_q;
  mem_funct_e  funct_q;

  exu_alu u_alu (
    .alu_a (id_pkt.alu_a),
    .alu_b (id_pkt.alu_b),
    .funct (id_pkt.alu_funct),
    .funcs (id_pkt.alu_funcs),
    .val   (alu_val)
  );

  exu_branch u_branch (
    .pkt     (id_pkt),
    .alu_val (alu_val),
    .npc     (npc)
  );

  assign id_fire   = id_valid & id_ready;
  assign rres_fire = mem_rres_valid & mem_rres_ready;
  assign wres_fire = mem_wres_valid & mem_wres_ready;

  assign is_sys   = id_pkt.opcode == OP_SYS;
  assign is_load  = id_pkt.opcode == OP_LOAD;
  assign is_store = id_pkt.opcode == OP_STORE;
  assign csr_addr = id_pkt.imm[11:0];
  assign ecall    = is_sys && (id_pkt.funct == 3'b000) && (csr_addr == 12'h000);

  // loads write back later, from the response
  always_comb begin
    case (id_pkt.opcode)
      OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_CALRI, OP_CALRR: gpr_wen_d = 1'b1;
      OP_SYS:  gpr_wen_d = |id_pkt.funct; // csr read
      default: gpr_wen_d = 1'b0;
    endcase
  end

  assign gpr_wdata_d = is_sys ? id_pkt.csr : alu_val;
  assign csr_wen1_d  = is_sys && ((|id_pkt.funct) || (csr_addr == 12'h000));

  always_ff @(posedge clk) begin
    if (rstn) begin
      gpr_wr.wen  <= 1'b0;
      csr_wr1.wen <= 1'b0;
      csr_wr2.wen <= 1'b0;
    end else begin
      gpr_wr.wen  <= (id_fire & gpr_wen_d) | rres_fire;
      csr_wr1.wen <= id_fire & csr_wen1_d;
      csr_wr2.wen <= id_fire & ecall;
      if (rres_fire) begin
        gpr_wr.waddr <= rd_q;
        gpr_wr.wdata <= mem_rdata;
      end else if (id_fire) begin
        gpr_wr.waddr <= id_pkt.rd;
        gpr_wr.wdata <= gpr_wdata_d;
      end
      if (id_fire) begin
        csr_wr1.waddr <= (|id_pkt.funct) ? csr_addr : CSR_MEPC; // ecall saves pc
        csr_wr1.wdata <= alu_val;
        csr_wr2.waddr <= CSR_MCAUSE;
        csr_wr2.wdata <= CAUSE_ECALL;
      end
    end
  end

  // operands held for the memory access
  always_ff @(posedge clk) begin
    if (id_fire) begin
      rd_q    <= id_pkt.rd;
      alu_q   <= alu_val;
      src2_q  <= id_pkt.src2;
      funct_q <= mem_funct_e'(id_pkt.funct);
    end
  end

  assign mem_rreq = '{raddr: alu_q, rfunc: funct_q};
  assign mem_wreq = '{waddr: alu_q, wdata: src2_q, wfunc: funct_q};

  // responses are always taken at once
  assign mem_rres_ready = 1'b1;
  assign mem_wres_ready = 1'b1;

  always_ff @(posedge clk) begin
    if (rstn) begin
      state          <= IDLE;
      id_ready       <= 1'b1;
      mem_rreq_valid <= 1'b0;
      mem_wreq_valid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (id_fire && is_load) begin
            state          <= LD_REQ;
            id_ready       <= 1'b0;
            mem_rreq_valid <= 1'b1;
          end else if (id_fire && is_store) begin
            state          <= ST_REQ;
            id_ready       <= 1'b0;
            mem_wreq_valid <= 1'b1;
          end
        end
        LD_REQ: begin
          if (mem_rreq_ready) begin
            state          <= LD_WAIT;
            mem_rreq_valid <= 1'b0;
          end
        end
        LD_WAIT: begin
          if (rres_fire) begin
            state    <= IDLE;
            id_ready <= 1'b1;
          end
        end
        ST_REQ: begin
          if (mem_wreq_ready) begin
            state          <= ST_WAIT;
            mem_wreq_valid <= 1'b0;
          end
        end
        ST_WAIT: begin
          if (wres_fire) begin
            state    <= IDLE;
            id_ready <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // back-to-back write pulses only from back-to-back acceptances
  assert property (@(posedge clk) disable iff (rstn)
    gpr_wr.wen && $past(gpr_wr.wen) |-> $past(id_fire));

  assert property (@(posedge clk) disable iff (rstn)
    mem_rreq_valid && !mem_rreq_ready |=> mem_rreq_valid && $stable(mem_rreq));
  assert property (@(posedge clk) disable iff (rstn)
    mem_wreq_valid && !mem_wreq_ready |=> mem_wreq_valid && $stable(mem_wreq));

  assert property (@(posedge clk) disable iff (rstn) state != IDLE |-> !id_ready);

endmodule

// File: hw/exu_branch.sv
module exu_branch (
  input  exu_pkg::id_pkt_t pkt,
  input  logic [31:0]      alu_val,
  output logic [31:0]      npc
);

  import exu_pkg::*;

  logic        alu_nz;
  logic        br_en;    // only meaningful for OP_BRANCH
  logic        sys_jump; // ecall / mret
  logic [31:0] base;
  logic [31:0] inc;
  logic [31:0] target;

  assign alu_nz   = |alu_val;
  assign sys_jump = (pkt.opcode == OP_SYS) && (pkt.funct == 3'b000);

  always_comb begin
    case (br_funct_e'(pkt.funct))
      BR_BEQ:          br_en = ~alu_nz;
      BR_BNE:          br_en = alu_nz;
      BR_BLT, BR_BLTU: br_en = alu_val[0];
      BR_BGE, BR_BGEU: br_en = ~alu_val[0];
      default:         br_en = 1'b0;
    endcase
  end

  always_comb begin
    if (pkt.opcode == OP_JALR) begin
      base = pkt.src1;
    end else if (sys_jump) begin
      base = pkt.csr; // mtvec for ecall, mepc for mret
    end else begin
      base = pkt.pc;
    end
  end

  always_comb begin
    case (pkt.opcode)
      OP_JAL, OP_JALR: inc = pkt.imm;
      OP_BRANCH:       inc = br_en ? pkt.imm : 32'd4;
      OP_SYS:          inc = sys_jump ? 32'd0 : 32'd4;
      default:         inc = 32'd4;
    endcase
  end

  assign target = base + inc;
  assign npc    = {target[31:1], 1'b0}; // jalr clears bit 0

endmodule

// File: hw/exu_alu.sv
module exu_alu (
  input  logic [31:0]          alu_a,
  input  logic [31:0]          alu_b,
  input  exu_pkg::alu_funct_e  funct,
  input  logic                 funcs,
  output logic [31:0]          val
);

  import exu_pkg::*;

  logic [31:0]        sum;
  logic [4:0]         shamt;
  logic               lt_s;
  logic               lt_u;
  logic [31:0]        srl;
  logic signed [31:0] sra;

  assign shamt = alu_b[4:0];

  // subtract doubles as the equality test for branches
  assign sum = funcs ? alu_a - alu_b : alu_a + alu_b;

  assign lt_s = $signed(alu_a) < $signed(alu_b);
  assign lt_u = alu_a < alu_b;

  // kept apart so the signed shift is not widened to unsigned
  assign srl = alu_a >> shamt;
  assign sra = $signed(alu_a) >>> shamt;

  always_comb begin
    case (funct)
      ALU_ADD:  val = sum;
      ALU_SLL:  val = alu_a << shamt;
      ALU_SLT:  val = {31'b0, lt_s}; // bit 0 feeds blt/bge
      ALU_SLTU: val = {31'b0, lt_u};
      ALU_XOR:  val = alu_a ^ alu_b;
      ALU_SR: begin
        if (funcs) begin
          val = sra;
        end else begin
          val = srl;
        end
      end
      ALU_OR:   val = alu_a | alu_b;
      ALU_AND:  val = alu_a & alu_b;
      default:  val = sum;
    endcase
  end

endmodule

// File: hw/exu_pkg.sv
package exu_pkg;

  // instruction bits 6:2
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_CALRI  = 5'b00100, // op-imm
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_CALRR  = 5'b01100, // reg-reg
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011,
    OP_SYS    = 5'b11100  // csr ops, ecall, mret
  } opcode_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_funct_e;

  // alu_funcs picks sub / sra on top of these
  typedef enum logic [2:0] {
    ALU_ADD  = 3'b000,
    ALU_SLL  = 3'b001,
    ALU_SLT  = 3'b010,
    ALU_SLTU = 3'b011,
    ALU_XOR  = 3'b100,
    ALU_SR   = 3'b101,
    ALU_OR   = 3'b110,
    ALU_AND  = 3'b111
  } alu_funct_e;

  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_funct_e;

  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;
  localparam logic [31:0] CAUSE_ECALL = 32'd11; // environment call from m-mode

  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS); // word index width

  // one decoded instruction from the decode stage
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] imm;
    logic [31:0] csr;     // csr read value, also mepc for mret
    opcode_e     opcode;
    logic [2:0]  funct;
    logic [4:0]  rd;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    alu_funct_e  alu_funct;
    logic        alu_funcs;
  } id_pkt_t;

  typedef struct packed {
    logic        wen;
    logic [4:0]  waddr;
    logic [31:0] wdata;
  } gpr_wr_t;

  typedef struct packed {
    logic        wen;
    logic [11:0] waddr;
    logic [31:0] wdata;
  } csr_wr_t;

  typedef struct packed {
    logic [31:0] raddr;
    mem_funct_e  rfunc;
  } mem_rreq_t;

  typedef struct packed {
    logic [31:0] waddr;
    logic [31:0] wdata;
    mem_funct_e  wfunc;
  } mem_wreq_t;

endpackage
